/* Makefile */
TOP = lookahead_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation reported errors"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* logic/lookahead_ctrl.sv */
/*
 * lookahead_ctrl
 * four-phase handshake FSM, request capture and result register
 */
`timescale 1ns/10ps
`default_nettype none

module lookahead_ctrl
    import route_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   req,
    input  x_addr_t     cur_x,
    input  y_addr_t     cur_y,
    input  x_addr_t     dest_x,
    input  y_addr_t     dest_y,
    input  port_code_t  dest_port,
    input  port_code_t  lk_code,
    output logic        ack,
    output port_code_t  lk_port,
    output x_addr_t     cur_x_q,
    output y_addr_t     cur_y_q,
    output x_addr_t     dest_x_q,
    output y_addr_t     dest_y_q,
    output port_code_t  dest_port_q
);

    typedef enum logic [1:0] {
        idle    = 2'd0,
        compute = 2'd1,   // datapath settling on captured request
        done    = 2'd2    // result held, ack high
    } state_e;

    state_e state;
    logic   capture;

    assign capture = (state == idle) && req;
    assign ack     = (state == done);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= idle;
            lk_port <= '0;
        end else begin
            case (state)
                idle:    if (req) state <= compute;
                compute: begin
                    lk_port <= lk_code;
                    state   <= done;
                end
                done:    if (!req) state <= idle;   // requester released
                default: state <= idle;
            endcase
        end
    end

    // request payload, only loaded on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            cur_x_q     <= cur_x;
            cur_y_q     <= cur_y;
            dest_x_q    <= dest_x;
            dest_y_q    <= dest_y;
            dest_port_q <= dest_port;
        end
    end

endmodule

`default_nettype wire

/* logic/lookahead_port_encode.sv */
/*
 * lookahead_port_encode
 * drops the entry port from the XY one-hot, giving a 4-bit port code
 */
`timescale 1ns/10ps
`default_nettype none

module lookahead_port_encode
    import route_pkg::*;
(
    input  port_onehot_t  xy_port,
    input  port_onehot_t  entry_port,
    output port_code_t    lk_code
);

    localparam int bin_w  = $clog2($bits(port_onehot_t));
    localparam int code_w = $clog2($bits(port_code_t));

    logic [bin_w-1:0]  xy_bin;
    logic [bin_w-1:0]  entry_bin;
    logic [bin_w-1:0]  shifted_bin;
    logic [code_w-1:0] code_bin;

    function automatic logic [bin_w-1:0] onehot_to_bin(input port_onehot_t oh);
        logic [bin_w-1:0] bin;
        bin = '0;
        for (int i = 0; i < $bits(port_onehot_t); i++) begin
            if (oh[i])
                bin = bin | i[bin_w-1:0];
        end
        return bin;
    endfunction

    assign xy_bin    = onehot_to_bin(xy_port);
    assign entry_bin = onehot_to_bin(entry_port);

    // ports above the entry port move down one slot
    assign shifted_bin = (entry_bin > xy_bin) ? xy_bin : xy_bin - 1'b1;
    assign code_bin    = shifted_bin[code_w-1:0];

    assign lk_code = port_code_t'(1) << code_bin;

endmodule

`default_nettype wire

/* logic/lookahead_router_top.sv */
/*
 * lookahead_router_top
 * look-ahead XY route computation with a four-phase req/ack handshake
 */
`timescale 1ns/10ps
`default_nettype none

module lookahead_router_top
    import route_pkg::*;
#(
    parameter int sw_loc = 0   // input port this unit sits on
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   req,
    input  x_addr_t     cur_x,
    input  y_addr_t     cur_y,
    input  x_addr_t     dest_x,
    input  y_addr_t     dest_y,
    input  port_code_t  dest_port,
    output logic        ack,
    output port_code_t  lk_port
);

    x_addr_t      cur_x_q, dest_x_q, next_x;
    y_addr_t      cur_y_q, dest_y_q, next_y;
    port_code_t   dest_port_q;
    port_code_t   lk_code;
    port_onehot_t entry_port;
    port_onehot_t xy_port;

    lookahead_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .dest_x      (dest_x),
        .dest_y      (dest_y),
        .dest_port   (dest_port),
        .lk_code     (lk_code),
        .ack         (ack),
        .lk_port     (lk_port),
        .cur_x_q     (cur_x_q),
        .cur_y_q     (cur_y_q),
        .dest_x_q    (dest_x_q),
        .dest_y_q    (dest_y_q),
        .dest_port_q (dest_port_q)
    );

    next_hop_predictor #(.sw_loc(sw_loc)) u_predictor (
        .cur_x      (cur_x_q),
        .cur_y      (cur_y_q),
        .dest_port  (dest_port_q),
        .next_x     (next_x),
        .next_y     (next_y),
        .entry_port (entry_port)
    );

    // routing decision taken as if already at the next router
    xy_port_select u_xy (
        .next_x  (next_x),
        .next_y  (next_y),
        .dest_x  (dest_x_q),
        .dest_y  (dest_y_q),
        .xy_port (xy_port)
    );

    lookahead_port_encode u_encode (
        .xy_port    (xy_port),
        .entry_port (entry_port),
        .lk_code    (lk_code)
    );

endmodule

`default_nettype wire

/* logic/next_hop_predictor.sv */
/*
 * next_hop_predictor
 * next router address and its entry port, derived from this router's output port
 */
`timescale 1ns/10ps
`default_nettype none

`include "route_cfg.svh"

module next_hop_predictor
    import route_pkg::*;
#(
    parameter int sw_loc = 0
) (
    input  x_addr_t       cur_x,
    input  y_addr_t       cur_y,
    input  port_code_t    dest_port,
    output x_addr_t       next_x,
    output y_addr_t       next_y,
    output port_onehot_t  entry_port
);

    localparam x_addr_t last_x = x_addr_t'(`MESH_NX - 1);
    localparam y_addr_t last_y = y_addr_t'(`MESH_NY - 1);

    port_onehot_t out_port;   // dest_port with sw_loc put back

    always_comb begin
        for (int i = 0; i < `ROUTER_PORTS; i++) begin
            if (i > sw_loc)
                out_port[i] = dest_port[i-1];
            else if (i == sw_loc)
                out_port[i] = 1'b0;   // never leaves on the port it came in
            else
                out_port[i] = dest_port[i];
        end
    end

    // one hop, wrapping at the mesh edges
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        if (out_port[port_east])
            next_x = (cur_x == last_x) ? '0 : cur_x + 1'b1;
        else if (out_port[port_north])
            next_y = (cur_y == '0) ? last_y : cur_y - 1'b1;
        else if (out_port[port_west])
            next_x = (cur_x == '0) ? last_x : cur_x - 1'b1;
        else if (out_port[port_south])
            next_y = (cur_y == last_y) ? '0 : cur_y + 1'b1;
    end

    // packet enters the next router on the opposite side
    assign entry_port[port_local] = out_port[port_local];
    assign entry_port[port_east]  = out_port[port_west];
    assign entry_port[port_west]  = out_port[port_east];
    assign entry_port[port_north] = out_port[port_south];
    assign entry_port[port_south] = out_port[port_north];

endmodule

`default_nettype wire

/* logic/route_cfg.svh */
/*
 * route computation config
 * mesh dimensions and router port count
 */
`ifndef ROUTE_CFG_SVH
`define ROUTE_CFG_SVH

// routers along x
`define MESH_NX 4

// routers along y
`define MESH_NY 4

// local + four mesh directions
`define ROUTER_PORTS 5

`endif

/* logic/route_pkg.sv */
/*
 * route_pkg
 * port indices, address and port-code types for the look-ahead router
 */
`default_nettype none

`include "route_cfg.svh"

package route_pkg;

    // address widths, at least one bit even for a single-column mesh
    localparam int x_w = (`MESH_NX > 1) ? $clog2(`MESH_NX) : 1;
    localparam int y_w = (`MESH_NY > 1) ? $clog2(`MESH_NY) : 1;

    // bit positions inside a port one-hot
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,   // y - 1
        port_west  = 3'd3,
        port_south = 3'd4    // y + 1
    } port_idx_e;

    typedef logic [x_w-1:0] x_addr_t;
    typedef logic [y_w-1:0] y_addr_t;

    typedef logic [`ROUTER_PORTS-1:0] port_onehot_t;   // all ports
    typedef logic [`ROUTER_PORTS-2:0] port_code_t;     // one port left out

endpackage

`default_nettype wire

/* logic/xy_port_select.sv */
/*
 * xy_port_select
 * dimension-ordered XY routing evaluated at the predicted next router
 */
`timescale 1ns/10ps
`default_nettype none

module xy_port_select
    import route_pkg::*;
(
    input  x_addr_t       next_x,
    input  y_addr_t       next_y,
    input  x_addr_t       dest_x,
    input  y_addr_t       dest_y,
    output port_onehot_t  xy_port
);

    // x first, y only once x matches
    always_comb begin
        xy_port = '0;
        if (dest_x > next_x)
            xy_port[port_east] = 1'b1;
        else if (dest_x < next_x)
            xy_port[port_west] = 1'b1;
        else if (dest_y < next_y)
            xy_port[port_north] = 1'b1;   // north lowers y
        else if (dest_y > next_y)
            xy_port[port_south] = 1'b1;
        else
            xy_port[port_local] = 1'b1;   // arrived
    end

endmodule

`default_nettype wire

/* test/lookahead_checker.sv */
/*
 * lookahead_checker
 * reset, handshake and result-hold assertions for lookahead_router_top
 */
`timescale 1ns/10ps
`default_nettype none

module lookahead_checker
    import route_pkg::*;
(
    input wire logic  clk,
    input wire logic  reset,
    input wire logic  req,
    input wire logic  ack,
    input port_code_t lk_port
);

    int fail_count = 0;   // assertion failures so far

    // first edge after reset release
    reset_state: assert property (@(posedge clk) $fell(reset) |-> (!ack && lk_port == '0))
        else begin
            $error("ack or lk_port not cleared after reset");
            fail_count++;
        end

    // req may only rise once ack is low
    req_rise: assert property (@(posedge clk) disable iff (reset) $rose(req) |-> !ack)
        else begin
            $error("req rose while ack was high");
            fail_count++;
        end

    ack_not_early: assert property (@(posedge clk) disable iff (reset)
        ($past(req) && !$past(req, 2)) |-> !ack)
        else begin
            $error("ack rose one edge after req");
            fail_count++;
        end

    ack_on_time: assert property (@(posedge clk) disable iff (reset)
        ($past(req, 2) && !$past(req, 3)) |-> ack)
        else begin
            $error("ack not high two edges after req");
            fail_count++;
        end

    ack_release: assert property (@(posedge clk) disable iff (reset) (ack && !req) |=> !ack)
        else begin
            $error("ack stayed high after req fell");
            fail_count++;
        end

    result_onehot: assert property (@(posedge clk) disable iff (reset) ack |-> $onehot(lk_port))
        else begin
            $error("lk_port is not one-hot while ack is high");
            fail_count++;
        end

    result_hold: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(lk_port))
        else begin
            $error("lk_port changed while ack was high");
            fail_count++;
        end

endmodule

bind lookahead_router_top lookahead_checker u_checker (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .ack     (ack),
    .lk_port (lk_port)
);

`default_nettype wire

/* test/lookahead_tb.sv */
/*
 * lookahead_tb
 * random and directed requests checked against a look-ahead XY model
 */
`timescale 1ns/10ps
`default_nettype none

`include "route_cfg.svh"

module lookahead_tb
    import route_pkg::*;
();

    localparam int sw_loc     = 0;
    localparam int n_random   = 200;
    localparam int n_trans    = n_random + 8;
    localparam int time_limit = (n_trans * 8 + 50) * 4;   // ns

    logic       clk;
    logic       reset;
    logic       req;
    x_addr_t    cur_x;
    y_addr_t    cur_y;
    x_addr_t    dest_x;
    y_addr_t    dest_y;
    port_code_t dest_port;
    logic       ack;
    port_code_t lk_port;

    logic [31:0] lfsr;
    int          errors;
    int          requests;
    int          tests;

    lookahead_router_top #(.sw_loc(sw_loc)) u_dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .dest_port (dest_port),
        .ack       (ack),
        .lk_port   (lk_port)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic x_addr_t rand_x();
        return x_addr_t'(take_bits(8) % `MESH_NX);
    endfunction

    function automatic y_addr_t rand_y();
        return y_addr_t'(take_bits(8) % `MESH_NY);
    endfunction

    function automatic port_code_t rand_port();
        return port_code_t'(4'b0001 << take_bits(2));
    endfunction

    // expected lk_port, ports numbered local 0, east 1, north 2, west 3, south 4
    function automatic port_code_t expected_port(input x_addr_t cx, input y_addr_t cy,
                                                 input x_addr_t dx, input y_addr_t dy,
                                                 input port_code_t dport);
        int out_idx;
        int entry_idx;
        int xy_idx;
        int nx;
        int ny;
        out_idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (dport[i])
                out_idx = (i < sw_loc) ? i : i + 1;   // skip over sw_loc
        end
        nx = int'(cx);
        ny = int'(cy);
        case (out_idx)
            1: nx = (nx + 1) % `MESH_NX;
            2: ny = (ny + `MESH_NY - 1) % `MESH_NY;
            3: nx = (nx + `MESH_NX - 1) % `MESH_NX;
            4: ny = (ny + 1) % `MESH_NY;
            default: ;
        endcase
        entry_idx = (out_idx == 0) ? 0 : ((out_idx + 1) % 4) + 1;   // opposite side
        if (int'(dx) > nx)
            xy_idx = 1;
        else if (int'(dx) < nx)
            xy_idx = 3;
        else if (int'(dy) < ny)
            xy_idx = 2;
        else if (int'(dy) > ny)
            xy_idx = 4;
        else
            xy_idx = 0;
        if (entry_idx <= xy_idx)
            xy_idx = xy_idx - 1;
        return 4'b0001 << xy_idx;
    endfunction

    task automatic run_request(input string name, input x_addr_t cx, input y_addr_t cy,
                               input x_addr_t dx, input y_addr_t dy,
                               input port_code_t dport, input port_code_t exp);
        logic [31:0] hold;
        hold = take_bits(2);
        @(posedge clk);
        cur_x     <= cx;
        cur_y     <= cy;
        dest_x    <= dx;
        dest_y    <= dy;
        dest_port <= dport;
        req       <= 1'b1;
        do @(negedge clk); while (!ack);
        assert (lk_port == exp)
        else begin
            $display("FAIL %s: expected %b, actual %b", name, exp, lk_port);
            errors++;
        end
        // slow requester, inputs wander while ack is held
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            cur_x     <= rand_x();
            dest_y    <= rand_y();
            dest_port <= rand_port();
        end
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack);
        requests++;
    endtask

    task automatic report_test(input string name, input int count, input int start_err);
        tests++;
        $display("test %s: %0d requests, %0d errors", name, count, errors - start_err);
    endtask

    task automatic run_random();
        int         start_err;
        x_addr_t    cx;
        x_addr_t    dx;
        y_addr_t    cy;
        y_addr_t    dy;
        port_code_t dp;
        start_err = errors;
        for (int n = 0; n < n_random; n++) begin
            cx = rand_x();
            cy = rand_y();
            dx = rand_x();
            dy = rand_y();
            dp = rand_port();
            run_request("random", cx, cy, dx, dy, dp, expected_port(cx, cy, dx, dy, dp));
        end
        report_test("random", n_random, start_err);
    endtask

    // code bit d is port d+1 with sw_loc at local
    task automatic run_edges(input bit arrive);
        int         start_err;
        x_addr_t    cx;
        x_addr_t    dx;
        y_addr_t    cy;
        y_addr_t    dy;
        port_code_t dp;
        start_err = errors;
        for (int d = 0; d < 4; d++) begin
            cx = rand_x();
            cy = rand_y();
            dx = rand_x();
            dy = rand_y();
            dp = port_code_t'(4'b0001 << d);
            if (arrive) begin
                dx = cx;
                dy = cy;
                case (d)
                    0: dx = x_addr_t'((int'(cx) + 1) % `MESH_NX);
                    1: dy = y_addr_t'((int'(cy) + `MESH_NY - 1) % `MESH_NY);
                    2: dx = x_addr_t'((int'(cx) + `MESH_NX - 1) % `MESH_NX);
                    default: dy = y_addr_t'((int'(cy) + 1) % `MESH_NY);
                endcase
                run_request("arrival", cx, cy, dx, dy, dp, 4'b0001);   // local
            end else begin
                case (d)
                    0: cx = x_addr_t'(`MESH_NX - 1);
                    1: cy = '0;
                    2: cx = '0;
                    default: cy = y_addr_t'(`MESH_NY - 1);
                endcase
                run_request("edge_wrap", cx, cy, dx, dy, dp,
                            expected_port(cx, cy, dx, dy, dp));
            end
        end
        report_test(arrive ? "arrival" : "edge_wrap", 4, start_err);
    endtask

    task automatic end_run(input bit timed_out);
        int total;
        total = errors + u_dut.u_checker.fail_count;
        $display("tests %0d, requests %0d, errors %0d", tests, requests, total);
        if (total == 0 && !timed_out)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req       = 1'b0;
        cur_x     = '0;
        cur_y     = '0;
        dest_x    = '0;
        dest_y    = '0;
        dest_port = '0;
        lfsr      = 32'heb5f;
        errors    = 0;
        requests  = 0;
        tests     = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        run_random();
        run_edges(1'b0);
        run_edges(1'b1);
        end_run(1'b0);
    end

    initial begin
        #(time_limit);
        $display("timeout: handshake did not complete within %0d ns", time_limit);
        end_run(1'b1);
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/route_pkg.sv
logic/next_hop_predictor.sv
logic/xy_port_select.sv
logic/lookahead_port_encode.sv
logic/lookahead_ctrl.sv
logic/lookahead_router_top.sv
test/lookahead_checker.sv
test/lookahead_tb.sv
